// File: hw/exec_pkg.sv
package exec_pkg;

   // Global history width used by fetch and the gshare predictor
   localparam int GHSR_WIDTH_DEFAULT = 8;

   typedef enum logic [3:0] {
      ALU_ADD   = 4'd0,
      ALU_SUB   = 4'd1,
      ALU_SLL   = 4'd2,
      ALU_SLT   = 4'd3,
      ALU_SLTU  = 4'd4,
      ALU_XOR   = 4'd5,
      ALU_SRL   = 4'd6,
      ALU_SRA   = 4'd7,
      ALU_OR    = 4'd8,
      ALU_AND   = 4'd9,
      ALU_LUI   = 4'd10, // Passes the right operand
      ALU_MUL   = 4'd11,
      ALU_MULHU = 4'd12,
      ALU_DIVU  = 4'd13,
      ALU_REMU  = 4'd14
   } alu_op_type;

   typedef enum logic [2:0] {
      BR_EQ  = 3'd0,
      BR_NE  = 3'd1,
      BR_LT  = 3'd2,
      BR_GE  = 3'd3,
      BR_LTU = 3'd4,
      BR_GEU = 3'd5
   } branch_op_type;

   typedef enum logic [1:0] {
      MEM_BYTE = 2'd0,
      MEM_HALF = 2'd1,
      MEM_WORD = 2'd2
   } mem_size_type;

   // Source of each register operand
   typedef enum logic [1:0] {
      FWD_NONE   = 2'b00, // Register file
      FWD_MEM_WB = 2'b01,
      FWD_EX_MEM = 2'b10
   } fwd_sel_type;

   typedef struct packed {
      alu_op_type    alu_op;
      logic          alu_src;   // Immediate replaces rs2
      logic          is_branch;
      branch_op_type branch_op;
      logic          is_jump;   // jal
      logic          is_jumpr;  // jalr
      logic          mem_read;
      logic          mem_write;
      mem_size_type  mem_size;
      logic          is_mul;    // alu_op is a multiply/divide
   } control_type;

   typedef struct packed {
      logic                          pred_taken;
      logic [31:0]                   pred_target;
      logic [GHSR_WIDTH_DEFAULT-1:0] pred_ghsr; // History fetch predicted with
   } branch_predict_type;

endpackage

// File: hw/operand_if.sv
`timescale 1ns/1ns

interface operand_if import exec_pkg::*; ();
   logic [31:0] rs1;       // After forwarding
   logic [31:0] rs2;
   logic [31:0] alu_left;
   logic [31:0] alu_right;
   logic [31:0] imm;
   logic [31:0] pc;
   control_type ctrl;

   modport source (
      output rs1, rs2, alu_left, alu_right, imm, pc, ctrl
   );

   modport sink (
      input rs1, rs2, alu_left, alu_right, imm, pc, ctrl
   );
endinterface

// File: hw/operand_select.sv
`timescale 1ns/1ns

module operand_select import exec_pkg::*; (
   input  logic [31:0] data1,
   input  logic [31:0] data2,
   input  logic [31:0] immediate_data,
   input  logic [31:0] pc,
   input  control_type control_in,
   input  fwd_sel_type fwd_sel_rs1,
   input  fwd_sel_type fwd_sel_rs2,
   input  logic [31:0] fwd_data_ex_mem,
   input  logic [31:0] fwd_data_mem_wb,
   operand_if.source   ops
);

   // Same mux for both source registers
   function automatic logic [31:0] fwd_pick(input fwd_sel_type sel, input logic [31:0] rf_data);
      logic [31:0] value;
      case (sel)
         FWD_MEM_WB: value = fwd_data_mem_wb;
         FWD_EX_MEM: value = fwd_data_ex_mem;
         default:    value = rf_data; // FWD_NONE and the unused code
      endcase
      return value;
   endfunction

   always_comb begin
      ops.rs1 = fwd_pick(fwd_sel_rs1, data1);
      ops.rs2 = fwd_pick(fwd_sel_rs2, data2);
      ops.alu_left = ops.rs1;
      if (control_in.alu_src) begin
         ops.alu_right = immediate_data; // I-type, lui
      end else begin
         ops.alu_right = ops.rs2;
      end
   end

   assign ops.imm  = immediate_data;
   assign ops.pc   = pc;
   assign ops.ctrl = control_in;

endmodule

// File: hw/alu.sv
`timescale 1ns/1ns

module alu import exec_pkg::*; (
   operand_if.sink     ops,
   output logic [31:0] alu_result
);

   logic [4:0]  shamt;
   logic [31:0] left;
   logic [31:0] right;

   assign left  = ops.alu_left;
   assign right = ops.alu_right;
   assign shamt = right[4:0]; // RV32 shifts use the low 5 bits

   always_comb begin
      case (ops.ctrl.alu_op)
         ALU_ADD:  alu_result = left + right;
         ALU_SUB:  alu_result = left - right;
         ALU_SLL:  alu_result = left << shamt;
         ALU_SLT: begin
            alu_result = {31'd0, $signed(left) < $signed(right)};
         end
         ALU_SLTU: begin
            alu_result = {31'd0, left < right};
         end
         ALU_XOR:  alu_result = left ^ right;
         ALU_SRL:  alu_result = left >> shamt;
         ALU_SRA: begin
            // Arithmetic shift keeps the sign bit
            alu_result = $unsigned($signed(left) >>> shamt);
         end
         ALU_OR:   alu_result = left | right;
         ALU_AND:  alu_result = left & right;
         ALU_LUI:  alu_result = right; // Upper immediate already in place
         default:  alu_result = 32'd0; // Multiply/divide handled elsewhere
      endcase
   end

endmodule

// File: hw/branch_unit.sv
`timescale 1ns/1ns

module branch_unit import exec_pkg::*; #(
   parameter int GHSR_WIDTH = GHSR_WIDTH_DEFAULT
) (
   operand_if.sink                 ops,
   input  branch_predict_type      branch_predict,
   output logic                    branch_taken,
   output logic [31:0]             branch_target_pc,
   output logic [31:0]             link_pc,
   output logic                    branch_flush,
   output logic                    update_ghsr,
   output logic [GHSR_WIDTH-1:0]   ghsr_restore
);

   logic        cond_true;
   logic        is_ctrl_flow;
   logic        dir_wrong;
   logic        target_wrong;
   logic [31:0] jalr_sum;

   // Condition from the comparison named by branch_op
   always_comb begin
      case (ops.ctrl.branch_op)
         BR_EQ:   cond_true = (ops.rs1 == ops.rs2);
         BR_NE:   cond_true = (ops.rs1 != ops.rs2);
         BR_LT:   cond_true = ($signed(ops.rs1) < $signed(ops.rs2));
         BR_GE:   cond_true = ($signed(ops.rs1) >= $signed(ops.rs2));
         BR_LTU:  cond_true = (ops.rs1 < ops.rs2);
         BR_GEU:  cond_true = (ops.rs1 >= ops.rs2);
         default: cond_true = 1'b0;
      endcase
   end

   assign is_ctrl_flow = ops.ctrl.is_branch | ops.ctrl.is_jump | ops.ctrl.is_jumpr;
   assign branch_taken = ops.ctrl.is_jump | ops.ctrl.is_jumpr
                       | (ops.ctrl.is_branch & cond_true);

   assign jalr_sum = ops.rs1 + ops.imm;

   always_comb begin
      if (ops.ctrl.is_jumpr) begin
         branch_target_pc = {jalr_sum[31:1], 1'b0}; // jalr clears bit 0
      end else begin
         branch_target_pc = ops.pc + ops.imm;
      end
   end

   assign link_pc = ops.pc + 32'd4;

   // Mispredicted direction, or taken to a different target
   assign dir_wrong    = (branch_taken != branch_predict.pred_taken);
   assign target_wrong = branch_taken & (branch_predict.pred_target != branch_target_pc);
   assign branch_flush = is_ctrl_flow & (dir_wrong | target_wrong);

   // Only conditional branches enter the gshare history
   assign update_ghsr  = ops.ctrl.is_branch;
   assign ghsr_restore = {branch_predict.pred_ghsr[GHSR_WIDTH-2:0], branch_taken};

endmodule

// File: hw/mul_div.sv
`timescale 1ns/1ns

module mul_div import exec_pkg::*; (
   input  logic        clk,
   input  logic        reset,
   operand_if.sink     ops,
   output logic [31:0] muldiv_result,
   output logic        muldiv_ready
);

   typedef enum logic [1:0] {
      IDLE,
      BUSY,
      DONE
   } state_type;

   state_type   state;
   logic [5:0]  step_cnt;    // 32 steps, then one select cycle
   alu_op_type  op_q;
   logic        is_div_q;
   logic [31:0] hi_q;        // Upper product or partial remainder
   logic [31:0] lo_q;        // Multiplier bits or quotient bits
   logic [31:0] operand_q;   // Multiplicand or divisor
   logic [31:0] result_q;
   logic [31:0] hi_next;
   logic [31:0] lo_next;
   logic [32:0] mul_sum;
   logic [32:0] div_shift;
   logic [32:0] div_trial;

   // One shift-add or restoring-subtract step
   always_comb begin
      mul_sum   = {1'b0, hi_q} + (lo_q[0] ? {1'b0, operand_q} : 33'd0);
      div_shift = {hi_q, lo_q[31]};
      div_trial = div_shift - {1'b0, operand_q};
      if (is_div_q) begin
         if (!div_trial[32]) begin
            hi_next = div_trial[31:0];
            lo_next = {lo_q[30:0], 1'b1};
         end else begin
            hi_next = div_shift[31:0]; // Restore
            lo_next = {lo_q[30:0], 1'b0};
         end
      end else begin
         hi_next = mul_sum[32:1];
         lo_next = {mul_sum[0], lo_q[31:1]};
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state    <= IDLE;
         step_cnt <= 6'd0;
      end else begin
         case (state)
            IDLE: if (ops.ctrl.is_mul) begin
               state    <= BUSY;
               step_cnt <= 6'd0;
            end
            BUSY: begin
               if (step_cnt == 6'd32) begin
                  state <= DONE;
               end
               step_cnt <= step_cnt + 6'd1;
            end
            DONE: if (!ops.ctrl.is_mul) begin
               state <= IDLE; // Pipeline has moved on
            end
            default: state <= IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == IDLE) begin
         op_q      <= ops.ctrl.alu_op;
         is_div_q  <= (ops.ctrl.alu_op == ALU_DIVU) || (ops.ctrl.alu_op == ALU_REMU);
         hi_q      <= 32'd0;
         lo_q      <= ops.rs1;
         operand_q <= ops.rs2;
      end else if (state == BUSY && step_cnt != 6'd32) begin
         hi_q <= hi_next;
         lo_q <= lo_next;
      end
      if (state == BUSY && step_cnt == 6'd32) begin
         // MULHU and REMU live in the upper half
         result_q <= (op_q == ALU_MULHU || op_q == ALU_REMU) ? hi_q : lo_q;
      end
   end

   assign muldiv_result = result_q;
   assign muldiv_ready  = (state == DONE);

endmodule

// File: hw/result_select.sv
`timescale 1ns/1ns

module result_select import exec_pkg::*; (
   operand_if.sink     ops,
   input  logic [31:0] alu_result,
   input  logic [31:0] link_pc,
   input  logic [31:0] muldiv_result,
   output logic [31:0] rd_data,
   output logic [31:0] memory_addr,
   output logic [31:0] memory_data
);

   assign memory_addr = ops.rs1 + ops.imm;

   // Store data repeated on every byte lane
   always_comb begin
      case (ops.ctrl.mem_size)
         MEM_BYTE: memory_data = {4{ops.rs2[7:0]}};
         MEM_HALF: memory_data = {2{ops.rs2[15:0]}};
         default:  memory_data = ops.rs2;
      endcase
   end

   always_comb begin
      if (ops.ctrl.is_jump || ops.ctrl.is_jumpr) begin
         rd_data = link_pc;       // Return address
      end else if (ops.ctrl.mem_read || ops.ctrl.mem_write) begin
         rd_data = memory_addr;
      end else if (ops.ctrl.is_mul) begin
         rd_data = muldiv_result;
      end else begin
         rd_data = alu_result;
      end
   end

endmodule

// File: hw/execute_stage.sv
`timescale 1ns/1ns

module execute_stage import exec_pkg::*; #(
   parameter int GHSR_WIDTH = GHSR_WIDTH_DEFAULT
) (
   input  logic                  clk,
   input  logic                  reset,
   input  logic [31:0]           data1,
   input  logic [31:0]           data2,
   input  logic [31:0]           pc,
   input  logic [31:0]           immediate_data,
   input  control_type           control_in,
   input  branch_predict_type    branch_predict,
   input  fwd_sel_type           fwd_sel_rs1,
   input  fwd_sel_type           fwd_sel_rs2,
   input  logic [31:0]           fwd_data_ex_mem,
   input  logic [31:0]           fwd_data_mem_wb,
   output control_type           control_out,
   output logic [31:0]           rd_data,
   output logic [31:0]           branch_target_pc,
   output logic                  branch_flush,
   output logic [31:0]           memory_data,
   output logic [31:0]           memory_addr,
   output logic                  ex2if_branch_valid,
   output logic                  ex2if_branch_taken,
   output logic [31:0]           ex2if_branch_addr,
   output logic [31:0]           ex2if_branch_target_addr,
   output logic                  ex2if_branch_update_ghsr,
   output logic [GHSR_WIDTH-1:0] ex2if_ghsr_restore,
   output logic                  muldiv_ready
);

   logic [31:0] alu_result;
   logic [31:0] muldiv_result;
   logic [31:0] link_pc;

   operand_if ops ();

   operand_select operand_select_i (
      .data1           (data1),
      .data2           (data2),
      .immediate_data  (immediate_data),
      .pc              (pc),
      .control_in      (control_in),
      .fwd_sel_rs1     (fwd_sel_rs1),
      .fwd_sel_rs2     (fwd_sel_rs2),
      .fwd_data_ex_mem (fwd_data_ex_mem),
      .fwd_data_mem_wb (fwd_data_mem_wb),
      .ops             (ops.source)
   );

   alu alu_i (
      .ops        (ops.sink),
      .alu_result (alu_result)
   );

   branch_unit #(
      .GHSR_WIDTH (GHSR_WIDTH)
   ) branch_unit_i (
      .ops              (ops.sink),
      .branch_predict   (branch_predict),
      .branch_taken     (ex2if_branch_taken),
      .branch_target_pc (branch_target_pc),
      .link_pc          (link_pc),
      .branch_flush     (branch_flush),
      .update_ghsr      (ex2if_branch_update_ghsr),
      .ghsr_restore     (ex2if_ghsr_restore)
   );

   mul_div mul_div_i (
      .clk           (clk),
      .reset         (reset),
      .ops           (ops.sink),
      .muldiv_result (muldiv_result),
      .muldiv_ready  (muldiv_ready)
   );

   result_select result_select_i (
      .ops           (ops.sink),
      .alu_result    (alu_result),
      .link_pc       (link_pc),
      .muldiv_result (muldiv_result),
      .rd_data       (rd_data),
      .memory_addr   (memory_addr),
      .memory_data   (memory_data)
   );

   // Feedback to fetch for the predictor
   assign ex2if_branch_valid       = control_in.is_branch | control_in.is_jump | control_in.is_jumpr;
   assign ex2if_branch_addr        = pc;
   assign ex2if_branch_target_addr = branch_target_pc;

   assign control_out = control_in;

endmodule

// File: sim/tb_execute_tasks.svh
task automatic new_cycle();
   @(posedge clk);
   #DRIVE_DELAY; // Inputs change just after the edge
endtask

task automatic idle_inputs();
   data1           = 32'd0;
   data2           = 32'd0;
   pc              = 32'd0;
   immediate_data  = 32'd0;
   control_in      = '0;
   branch_predict  = '0;
   fwd_sel_rs1     = FWD_NONE;
   fwd_sel_rs2     = FWD_NONE;
   fwd_data_ex_mem = 32'd0;
   fwd_data_mem_wb = 32'd0;
endtask

task automatic randomize_operands();
   idle_inputs();
   data1           = $urandom();
   data2           = $urandom();
   pc              = $urandom() & 32'hffff_fffc; // Word aligned
   immediate_data  = $urandom();
   fwd_data_ex_mem = $urandom();
   fwd_data_mem_wb = $urandom();
endtask

function automatic logic [31:0] fwd_value(input fwd_sel_type sel, input logic [31:0] rf);
   if (sel == FWD_EX_MEM) return fwd_data_ex_mem;
   if (sel == FWD_MEM_WB) return fwd_data_mem_wb;
   return rf;
endfunction

// Flipping the sign bit turns signed order into unsigned order
function automatic logic signed_less(input logic [31:0] a, input logic [31:0] b);
   return (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000);
endfunction

function automatic logic [31:0] alu_model(input alu_op_type op, input logic [31:0] a,
                                          input logic [31:0] b);
   logic [4:0] sh;
   sh = b[4:0];
   case (op)
      ALU_ADD:  return a + b;
      ALU_SUB:  return a + ~b + 32'd1;
      ALU_SLL:  return a << sh;
      ALU_SLT:  return {31'd0, signed_less(a, b)};
      ALU_SLTU: return {31'd0, a < b};
      ALU_XOR:  return a ^ b;
      ALU_SRL:  return a >> sh;
      ALU_SRA:  return (a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'd0);
      ALU_OR:   return a | b;
      ALU_AND:  return a & b;
      ALU_LUI:  return b;
      default:  return 32'd0;
   endcase
endfunction

function automatic logic branch_model(input branch_op_type op, input logic [31:0] a,
                                      input logic [31:0] b);
   case (op)
      BR_EQ:   return a == b;
      BR_NE:   return a != b;
      BR_LT:   return signed_less(a, b);
      BR_GE:   return !signed_less(a, b);
      BR_LTU:  return a < b;
      default: return a >= b;
   endcase
endfunction

function automatic logic [31:0] muldiv_model(input alu_op_type op, input logic [31:0] a,
                                             input logic [31:0] b);
   logic [63:0] prod;
   prod = {32'd0, a} * {32'd0, b};
   case (op)
      ALU_MUL:   return prod[31:0];
      ALU_MULHU: return prod[63:32];
      ALU_DIVU:  return (b == 32'd0) ? 32'hffff_ffff : a / b;
      default:   return (b == 32'd0) ? a : a % b;
   endcase
endfunction

task automatic test_alu_ops();
   logic [31:0] a;
   logic [31:0] b;
   check_hex("muldiv_ready", 32'(muldiv_ready), 32'd0);
   for (int op = 0; op <= int'(ALU_LUI); op++) begin
      for (int f = 0; f < 6; f++) begin
         new_cycle();
         randomize_operands();
         fwd_sel_rs1        = fwd_sel_type'(f % 3);
         fwd_sel_rs2        = fwd_sel_type'((f + 1) % 3);
         control_in.alu_op  = alu_op_type'(op);
         control_in.alu_src = (f >= 3); // Immediate form
         a = fwd_value(fwd_sel_rs1, data1);
         b = control_in.alu_src ? immediate_data : fwd_value(fwd_sel_rs2, data2);
         #(CLK_PERIOD / 2);
         check_hex("rd_data", rd_data, alu_model(control_in.alu_op, a, b));
         check_hex("control_out", 32'(control_out), 32'(control_in));
         check_hex("ex2if_branch_valid", 32'(ex2if_branch_valid), 32'd0);
      end
   end
endtask

task automatic test_branches();
   logic [31:0]                   a;
   logic [31:0]                   target;
   logic                          taken;
   logic                          flush;
   logic [GHSR_WIDTH_DEFAULT-1:0] ghsr;
   logic [GHSR_WIDTH_DEFAULT-1:0] restore;
   for (int op = 0; op < 6; op++) begin
      for (int rel = 0; rel < 3; rel++) begin
         for (int p = 0; p < 3; p++) begin
            new_cycle();
            randomize_operands();
            // Low bits fixed so that +5 and -5 never wrap
            a     = ($urandom() & 32'hfff0_0000) | 32'h100;
            data1 = a;
            data2 = (rel == 0) ? a : (rel == 1) ? a + 32'd5 : a - 32'd5;
            immediate_data       = $urandom() & 32'h1ffe;
            control_in.is_branch = 1'b1;
            control_in.branch_op = branch_op_type'(op);
            taken  = branch_model(control_in.branch_op, data1, data2);
            target = pc + immediate_data;
            ghsr   = GHSR_WIDTH_DEFAULT'($urandom());
            branch_predict.pred_taken  = (p != 0);
            branch_predict.pred_target = (p == 2) ? target ^ 32'h40 : target;
            branch_predict.pred_ghsr   = ghsr;
            flush   = (taken != branch_predict.pred_taken)
                    || (taken && branch_predict.pred_target != target);
            restore = (ghsr << 1) | GHSR_WIDTH_DEFAULT'(taken);
            #(CLK_PERIOD / 2);
            check_hex("ex2if_branch_taken", 32'(ex2if_branch_taken), 32'(taken));
            check_hex("branch_target_pc", branch_target_pc, target);
            check_hex("ex2if_branch_target_addr", ex2if_branch_target_addr, target);
            check_hex("branch_flush", 32'(branch_flush), 32'(flush));
            check_hex("ex2if_branch_valid", 32'(ex2if_branch_valid), 32'd1);
            check_hex("ex2if_branch_addr", ex2if_branch_addr, pc);
            check_hex("ex2if_branch_update_ghsr", 32'(ex2if_branch_update_ghsr), 32'd1);
            check_hex("ex2if_ghsr_restore", 32'(ex2if_ghsr_restore), 32'(restore));
         end
      end
   end
endtask

task automatic test_jumps();
   logic [31:0] target;
   for (int j = 0; j < 8; j++) begin
      new_cycle();
      randomize_operands();
      control_in.is_jump  = (j % 2 == 0);
      control_in.is_jumpr = (j % 2 == 1);
      target = control_in.is_jumpr ? ((data1 + immediate_data) & 32'hffff_fffe)
                                   : pc + immediate_data;
      // Correct prediction, then not taken, then wrong target
      branch_predict.pred_taken  = (j < 4) || (j >= 6);
      branch_predict.pred_target = (j >= 6) ? target + 32'd8 : target;
      #(CLK_PERIOD / 2);
      check_hex("rd_data", rd_data, pc + 32'd4);
      check_hex("branch_target_pc", branch_target_pc, target);
      check_hex("ex2if_branch_taken", 32'(ex2if_branch_taken), 32'd1);
      check_hex("ex2if_branch_valid", 32'(ex2if_branch_valid), 32'd1);
      check_hex("branch_flush", 32'(branch_flush), 32'(j >= 4));
      check_hex("ex2if_branch_update_ghsr", 32'(ex2if_branch_update_ghsr), 32'd0);
   end
endtask

task automatic test_loads_stores();
   logic [31:0] lanes;
   for (int s = 0; s < 3; s++) begin
      for (int w = 0; w < 2; w++) begin
         new_cycle();
         randomize_operands();
         control_in.alu_src   = 1'b1;
         control_in.mem_size  = mem_size_type'(s);
         control_in.mem_read  = (w == 0);
         control_in.mem_write = (w == 1);
         case (s)
            0:       lanes = (data2 & 32'h0000_00ff) * 32'h0101_0101;
            1:       lanes = (data2 & 32'h0000_ffff) * 32'h0001_0001;
            default: lanes = data2;
         endcase
         #(CLK_PERIOD / 2);
         check_hex("memory_addr", memory_addr, data1 + immediate_data);
         check_hex("rd_data", rd_data, data1 + immediate_data);
         check_hex("memory_data", memory_data, lanes);
      end
   end
endtask

task automatic test_muldiv();
   alu_op_type  op;
   logic [31:0] a;
   logic [31:0] b;
   int          cycles;
   for (int k = 0; k < 12; k++) begin
      op = alu_op_type'(int'(ALU_MUL) + k % 4);
      a  = (k / 4 == 2) ? 32'hffff_ffff : $urandom();
      b  = (k / 4 == 0) ? $urandom() : (k / 4 == 1) ? 32'd0 : 32'hffff_ffff;
      new_cycle();
      idle_inputs();
      data1             = a;
      data2             = b;
      control_in.alu_op = op;
      control_in.is_mul = 1'b1;
      @(posedge clk); // Start edge
      cycles = 0;
      do begin
         @(posedge clk);
         #1;
         cycles++;
         if (cycles > MULDIV_TIMEOUT) begin
            stop_with_failure($sformatf("muldiv_ready did not rise within %0d cycles",
                                        MULDIV_TIMEOUT));
         end
      end while (!muldiv_ready);
      assert (cycles == 33) else begin
         stop_with_failure($sformatf("muldiv_ready rose %0d cycles after the start edge, not 33",
                                     cycles));
      end
      check_hex("rd_data", rd_data, muldiv_model(op, a, b));
      new_cycle();
      control_in.is_mul = 1'b0;
      @(posedge clk);
      #1;
      check_hex("muldiv_ready", 32'(muldiv_ready), 32'd0);
   end
endtask

// File: sim/tb_execute_stage.sv
`timescale 1ns/1ns

module tb_execute_stage import exec_pkg::*; ();

   localparam int          CLK_PERIOD     = 20;
   localparam int          DRIVE_DELAY    = 2;
   localparam int          MULDIV_TIMEOUT = 100;
   localparam logic [31:0] SEED           = 32'he84a_c130;

   logic                          clk;
   logic                          reset;
   logic [31:0]                   data1;
   logic [31:0]                   data2;
   logic [31:0]                   pc;
   logic [31:0]                   immediate_data;
   control_type                   control_in;
   branch_predict_type            branch_predict;
   fwd_sel_type                   fwd_sel_rs1;
   fwd_sel_type                   fwd_sel_rs2;
   logic [31:0]                   fwd_data_ex_mem;
   logic [31:0]                   fwd_data_mem_wb;
   control_type                   control_out;
   logic [31:0]                   rd_data;
   logic [31:0]                   branch_target_pc;
   logic                          branch_flush;
   logic [31:0]                   memory_data;
   logic [31:0]                   memory_addr;
   logic                          ex2if_branch_valid;
   logic                          ex2if_branch_taken;
   logic [31:0]                   ex2if_branch_addr;
   logic [31:0]                   ex2if_branch_target_addr;
   logic                          ex2if_branch_update_ghsr;
   logic [GHSR_WIDTH_DEFAULT-1:0] ex2if_ghsr_restore;
   logic                          muldiv_ready;

   execute_stage #(
      .GHSR_WIDTH (GHSR_WIDTH_DEFAULT)
   ) execute_stage_i (.*);

   task automatic stop_with_failure(input string reason);
      $display("%s", reason);
      $display("SIMULATION FAILED");
      $fatal(1, "Run aborted");
   endtask

   task automatic check_hex(input string name, input logic [31:0] got, input logic [31:0] exp);
      assert (got === exp) else begin
         stop_with_failure($sformatf("Error: %s is 0x%h, expected 0x%h", name, got, exp));
      end
   endtask

   `include "tb_execute_tasks.svh"

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   initial begin
      void'($urandom(SEED));
      reset = 1'b1;
      idle_inputs();
      repeat (8) @(posedge clk);
      #DRIVE_DELAY;
      reset = 1'b0;

      test_alu_ops();
      test_branches();
      test_jumps();
      test_loads_stores();
      test_muldiv();

      $display("SIMULATION PASSED");
      $finish;
   end

endmodule

// File: sources.f
+incdir+sim
hw/exec_pkg.sv
hw/operand_if.sv
hw/operand_select.sv
hw/alu.sv
hw/branch_unit.sv
hw/mul_div.sv
hw/result_select.sv
hw/execute_stage.sv
sim/tb_execute_stage.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_execute_stage
FILELIST  := sources.f
OBJ_DIR   := obj_dir

SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(filter %.sv %.v,$(shell cat $(FILELIST)))
HEADERS   := $(wildcard sim/*.svh)

.PHONY: all run clean

all: $(SIM_BIN)

# Rebuilt only when a source, header or the file list changes
$(SIM_BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)
